// File: logic/mouse_pkg.sv
// PS/2 mouse shared types
package mouse_pkg;

    // One movement packet as collected from the device
    typedef struct packed {
        logic [7:0] status;
        logic [7:0] dx;
        logic [7:0] dy;
    } mouse_packet_t;

    // Received device-to-host frame
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       err;
    } ps2_rx_t;

    // Host-to-device transmit request
    typedef struct packed {
        logic [7:0] data;
        logic       send;
    } ps2_tx_t;

    // Command and response byte codes
    typedef enum logic [7:0] {
        CMD_RESET    = 8'hFF,
        CMD_ENABLE   = 8'hF4,
        RSP_ACK      = 8'hFA,
        RSP_SELFTEST = 8'hAA,
        RSP_ID       = 8'h00
    } ps2_cmd_e;

    // Master FSM states
    typedef enum logic [3:0] {
        S_SEND_RESET,
        S_WAIT_ACK1,
        S_WAIT_AA,
        S_WAIT_ID,
        S_SEND_ENABLE,
        S_WAIT_ACK2,
        S_BYTE0,
        S_BYTE1,
        S_BYTE2
    } master_state_e;

    // Bus register map
    localparam logic [7:0] ADDR_STATUS = 8'hA0;
    localparam logic [7:0] ADDR_POS_X  = 8'hA1;
    localparam logic [7:0] ADDR_POS_Y  = 8'hA2;

    // Status byte bit positions
    localparam int STAT_ONE = 3;
    localparam int STAT_XS  = 4;
    localparam int STAT_YS  = 5;
    localparam int STAT_XO  = 6;
    localparam int STAT_YO  = 7;

endpackage

// File: logic/ps2_receiver.sv
// PS/2 device-to-host receiver
`timescale 1ns/1ns

module ps2_receiver (
    input  logic               CLK,
    input  logic               RESETN,
    input  logic               clk_mouse,
    input  logic               data_mouse,
    input  logic               tx_busy,
    output mouse_pkg::ps2_rx_t rx
);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_last;
    logic       clk_fall;
    logic [3:0] bit_cnt;
    logic [9:0] shift_q;
    logic       frame_err;
    logic       valid_q;
    logic [7:0] data_q;
    logic       err_q;

    // Two-flop synchronizers, lines idle high
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_last  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], clk_mouse};
            data_sync <= {data_sync[0], data_mouse};
            clk_last  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_last & ~clk_sync[1];

    // shift_q holds start in bit 0, data in 8:1, parity in bit 9
    // Odd parity over data and parity bit must give 1
    assign frame_err = shift_q[0] | ~(^shift_q[9:1]) | ~data_sync[1];

    // Bit counter, cleared while the host owns the lines
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            bit_cnt <= 4'd0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (tx_busy) begin
                bit_cnt <= 4'd0;
            end else if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= 4'd0;
                    valid_q <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Frame payload, LSB first
    always_ff @(posedge CLK) begin
        if (clk_fall) begin
            shift_q <= {data_sync[1], shift_q[9:1]};
            // Stop bit edge closes the frame
            if (bit_cnt == 4'd10) begin
                data_q <= shift_q[8:1];
                err_q  <= frame_err;
            end
        end
    end

    assign rx = '{data: data_q, valid: valid_q, err: err_q};

endmodule

// File: logic/ps2_transmitter.sv
// PS/2 host-to-device transmitter
`timescale 1ns/1ns

module ps2_transmitter #(
    parameter int INHIBIT_CYCLES = 5000
) (
    input  logic               CLK,
    input  logic               RESETN,
    input  mouse_pkg::ps2_tx_t tx,
    inout  wire                clk_mouse,
    inout  wire                data_mouse,
    output logic               tx_busy,
    output logic               tx_done
);

    localparam int CNT_W = $clog2(INHIBIT_CYCLES + 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_INHIBIT,
        TX_BITS,
        TX_ACK
    } tx_state_e;

    tx_state_e  state;
    logic [CNT_W-1:0] inhibit_cnt;
    logic [3:0] bit_cnt;
    logic [9:0] shift_q;
    logic       clk_oe;
    logic       data_oe;
    logic       done_q;
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_last;
    logic       clk_fall;

    // Device clock and data back into the CLK domain
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_last  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], clk_mouse};
            data_sync <= {data_sync[0], data_mouse};
            clk_last  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_last & ~clk_sync[1];

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            state       <= TX_IDLE;
            inhibit_cnt <= '0;
            bit_cnt     <= 4'd0;
            clk_oe      <= 1'b0;
            data_oe     <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (tx.send) begin
                        clk_oe      <= 1'b1;
                        inhibit_cnt <= '0;
                        state       <= TX_INHIBIT;
                    end
                end
                TX_INHIBIT: begin
                    // Request-to-send: data low, then let the device clock
                    if (inhibit_cnt == CNT_W'(INHIBIT_CYCLES - 1)) begin
                        data_oe <= 1'b1;
                        clk_oe  <= 1'b0;
                        bit_cnt <= 4'd0;
                        state   <= TX_BITS;
                    end else begin
                        inhibit_cnt <= inhibit_cnt + 1'b1;
                    end
                end
                TX_BITS: begin
                    // 8 data bits, parity, then stop as a released line
                    if (clk_fall) begin
                        data_oe <= ~shift_q[0];
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd9) begin
                            state <= TX_ACK;
                        end
                    end
                end
                TX_ACK: begin
                    if (clk_fall && !data_sync[1]) begin
                        clk_oe  <= 1'b0;
                        data_oe <= 1'b0;
                        done_q  <= 1'b1;
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Stop, odd parity and data, shifted out LSB first
    always_ff @(posedge CLK) begin
        if (state == TX_IDLE && tx.send) begin
            shift_q <= {1'b1, ~(^tx.data), tx.data};
        end else if (state == TX_BITS && clk_fall) begin
            shift_q <= {1'b0, shift_q[9:1]};
        end
    end

    // Open-drain drivers
    assign clk_mouse  = clk_oe  ? 1'b0 : 1'bz;
    assign data_mouse = data_oe ? 1'b0 : 1'bz;

    assign tx_busy = (state != TX_IDLE);
    assign tx_done = done_q;

endmodule

// File: logic/mouse_master.sv
// PS/2 mouse initialization and packet FSM
`timescale 1ns/1ns

module mouse_master (
    input  logic                     CLK,
    input  logic                     RESETN,
    input  mouse_pkg::ps2_rx_t       rx,
    input  logic                     tx_done,
    input  logic                     INTERRUPT_ACK,
    output mouse_pkg::ps2_tx_t       tx,
    output mouse_pkg::mouse_packet_t packet,
    output logic                     packet_valid,
    output logic                     SEND_INTERRUPT
);

    import mouse_pkg::*;

    master_state_e state;
    logic          cmd_issued;
    logic          send_q;
    logic [7:0]    cmd_q;
    logic [7:0]    status_q;
    logic [7:0]    dx_q;
    logic [7:0]    dy_q;
    logic          good_byte;
    logic          irq_q;

    assign good_byte = rx.valid && !rx.err;

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            state        <= S_SEND_RESET;
            cmd_issued   <= 1'b0;
            send_q       <= 1'b0;
            packet_valid <= 1'b0;
        end else begin
            send_q       <= 1'b0;
            packet_valid <= 1'b0;
            case (state)
                S_SEND_RESET, S_SEND_ENABLE: begin
                    // One send strobe per visit, then wait for the device ack bit
                    if (!cmd_issued) begin
                        send_q     <= 1'b1;
                        cmd_issued <= 1'b1;
                    end else if (tx_done) begin
                        cmd_issued <= 1'b0;
                        state <= (state == S_SEND_RESET) ? S_WAIT_ACK1 : S_WAIT_ACK2;
                    end
                end
                S_WAIT_ACK1: begin
                    if (rx.valid) begin
                        state <= (good_byte && rx.data == RSP_ACK) ? S_WAIT_AA : S_SEND_RESET;
                    end
                end
                S_WAIT_AA: begin
                    if (rx.valid) begin
                        state <= (good_byte && rx.data == RSP_SELFTEST) ? S_WAIT_ID
                                                                        : S_SEND_RESET;
                    end
                end
                S_WAIT_ID: begin
                    if (rx.valid) begin
                        state <= (good_byte && rx.data == RSP_ID) ? S_SEND_ENABLE
                                                                  : S_SEND_RESET;
                    end
                end
                S_WAIT_ACK2: begin
                    if (rx.valid) begin
                        state <= (good_byte && rx.data == RSP_ACK) ? S_BYTE0 : S_SEND_RESET;
                    end
                end
                S_BYTE0: begin
                    // Resync on the always-one status bit
                    if (good_byte && rx.data[STAT_ONE]) begin
                        state <= S_BYTE1;
                    end
                end
                S_BYTE1: begin
                    if (rx.valid) begin
                        state <= rx.err ? S_BYTE0 : S_BYTE2;
                    end
                end
                S_BYTE2: begin
                    if (rx.valid) begin
                        packet_valid <= !rx.err;
                        state        <= S_BYTE0;
                    end
                end
                default: state <= S_SEND_RESET;
            endcase
        end
    end

    // Command byte and packet payload
    always_ff @(posedge CLK) begin
        if (state == S_SEND_RESET && !cmd_issued) begin
            cmd_q <= CMD_RESET;
        end else if (state == S_SEND_ENABLE && !cmd_issued) begin
            cmd_q <= CMD_ENABLE;
        end
        if (good_byte) begin
            case (state)
                S_BYTE0: status_q <= rx.data;
                S_BYTE1: dx_q     <= rx.data;
                S_BYTE2: dy_q     <= rx.data;
                default: ;
            endcase
        end
    end

    // A fresh packet wins over an ack in the same cycle
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            irq_q <= 1'b0;
        end else if (packet_valid) begin
            irq_q <= 1'b1;
        end else if (INTERRUPT_ACK) begin
            irq_q <= 1'b0;
        end
    end

    assign tx             = '{data: cmd_q, send: send_q};
    assign packet         = '{status: status_q, dx: dx_q, dy: dy_q};
    assign SEND_INTERRUPT = irq_q;

endmodule

// File: logic/mouse_position.sv
// Mouse X/Y position accumulator
`timescale 1ns/1ns

module mouse_position #(
    parameter int MAX_X = 159,
    parameter int MAX_Y = 119
) (
    input  logic                     CLK,
    input  logic                     RESETN,
    input  mouse_pkg::mouse_packet_t packet,
    input  logic                     packet_valid,
    output logic [7:0]               pos_x,
    output logic [7:0]               pos_y
);

    import mouse_pkg::*;

    logic [7:0] next_x;
    logic [7:0] next_y;

    // Add a 9-bit signed delta and clamp to 0..max_pos
    function automatic logic [7:0] step_pos(
        input logic [7:0] pos,
        input logic [7:0] delta,
        input logic       sign,
        input logic       ovf,
        input logic [7:0] max_pos
    );
        logic        [8:0] delta9;
        logic signed [9:0] sum;
        // Overflowed deltas are not trustworthy
        delta9 = ovf ? 9'd0 : {sign, delta};
        sum    = $signed({2'b00, pos}) + $signed({delta9[8], delta9});
        if (sum < 0) begin
            step_pos = 8'd0;
        end else if (sum > $signed({2'b00, max_pos})) begin
            step_pos = max_pos;
        end else begin
            step_pos = sum[7:0];
        end
    endfunction

    always_comb begin
        next_x = step_pos(pos_x, packet.dx, packet.status[STAT_XS],
                          packet.status[STAT_XO], 8'(MAX_X));
        // Positive dy moves up the Y axis
        next_y = step_pos(pos_y, packet.dy, packet.status[STAT_YS],
                          packet.status[STAT_YO], 8'(MAX_Y));
    end

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            pos_x <= 8'(MAX_X / 2);
            pos_y <= 8'(MAX_Y / 2);
        end else if (packet_valid) begin
            pos_x <= next_x;
            pos_y <= next_y;
        end
    end

endmodule

// File: logic/mouse_top.sv
// PS/2 mouse subsystem top
`timescale 1ns/1ns

module mouse_top #(
    parameter int INHIBIT_CYCLES = 5000,
    parameter int MAX_X          = 159,
    parameter int MAX_Y          = 119
) (
    input  logic       CLK,
    input  logic       RESETN,
    inout  wire        CLK_MOUSE,
    inout  wire        DATA_MOUSE,
    inout  wire  [7:0] BUS_DATA,
    input  logic [7:0] BUS_ADDR,
    input  logic       BUS_WE,
    output logic       SEND_INTERRUPT,
    input  logic       INTERRUPT_ACK
);

    import mouse_pkg::*;

    ps2_rx_t       rx;
    ps2_tx_t       tx;
    mouse_packet_t packet;
    logic          packet_valid;
    logic          tx_busy;
    logic          tx_done;
    logic [7:0]    pos_x;
    logic [7:0]    pos_y;
    logic [7:0]    status_q;
    logic          rd_en;
    logic [7:0]    rd_data;

    // Status register, cleared at reset
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            status_q <= 8'h00;
        end else if (packet_valid) begin
            status_q <= packet.status;
        end
    end

    // Read decode, driven one cycle after the address
    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= !BUS_WE && (BUS_ADDR == ADDR_STATUS || BUS_ADDR == ADDR_POS_X ||
                                 BUS_ADDR == ADDR_POS_Y);
        end
    end

    always_ff @(posedge CLK) begin
        case (BUS_ADDR)
            ADDR_STATUS: rd_data <= status_q;
            ADDR_POS_X:  rd_data <= pos_x;
            ADDR_POS_Y:  rd_data <= pos_y;
            default:     rd_data <= 8'h00;
        endcase
    end

    // Shared bus, read only
    assign BUS_DATA = rd_en ? rd_data : 8'hzz;

    ps2_receiver u_receiver (
        .CLK        (CLK),
        .RESETN     (RESETN),
        .clk_mouse  (CLK_MOUSE),
        .data_mouse (DATA_MOUSE),
        .tx_busy    (tx_busy),
        .rx         (rx)
    );

    ps2_transmitter #(.INHIBIT_CYCLES(INHIBIT_CYCLES)) u_transmitter (
        .CLK        (CLK),
        .RESETN     (RESETN),
        .tx         (tx),
        .clk_mouse  (CLK_MOUSE),
        .data_mouse (DATA_MOUSE),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    mouse_master u_master (
        .CLK            (CLK),
        .RESETN         (RESETN),
        .rx             (rx),
        .tx_done        (tx_done),
        .INTERRUPT_ACK  (INTERRUPT_ACK),
        .tx             (tx),
        .packet         (packet),
        .packet_valid   (packet_valid),
        .SEND_INTERRUPT (SEND_INTERRUPT)
    );

    mouse_position #(.MAX_X(MAX_X), .MAX_Y(MAX_Y)) u_position (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .packet       (packet),
        .packet_valid (packet_valid),
        .pos_x        (pos_x),
        .pos_y        (pos_y)
    );

endmodule

// File: dv/ps2_mouse_model.sv
// Behavioral PS/2 mouse
`timescale 1ns/1ns

module ps2_mouse_model #(
    parameter int NUM_PACKETS = 200
) (
    input logic CLK,
    input logic RESETN,
    inout wire  clk_mouse,
    inout wire  data_mouse
);

    import mouse_pkg::*;

    logic       clk_oe = 1'b0;
    logic       data_oe = 1'b0;
    logic [7:0] pkt_status;
    logic [7:0] pkt_dx;
    logic [7:0] pkt_dy;
    logic       pkt_bad;
    logic       in_packet = 1'b0;
    logic       all_sent = 1'b0;
    int         err_count = 0;
    event       pkt_sent;

    assign clk_mouse  = clk_oe  ? 1'b0 : 1'bz;
    assign data_mouse = data_oe ? 1'b0 : 1'bz;

    // Clock in one host command at a 20-cycle bit period and acknowledge it
    task automatic receive_cmd(input logic [7:0] expected);
        logic [9:0] bits;
        // Request-to-send is a released clock with data held low
        wait (clk_mouse === 1'b1 && data_mouse === 1'b0);
        repeat (10) @(posedge CLK);
        for (int i = 0; i < 10; i++) begin
            clk_oe <= 1'b1;
            repeat (10) @(posedge CLK);
            clk_oe <= 1'b0;
            repeat (5) @(posedge CLK);
            bits[i] = data_mouse;
            repeat (5) @(posedge CLK);
        end
        // Ack bit has data low ahead of the last falling edge
        data_oe <= 1'b1;
        repeat (5) @(posedge CLK);
        clk_oe <= 1'b1;
        repeat (10) @(posedge CLK);
        clk_oe <= 1'b0;
        repeat (5) @(posedge CLK);
        data_oe <= 1'b0;
        if (bits[7:0] !== expected) begin
            $display("error at %0t: mouse got command %h instead of %h", $time, bits[7:0],
                     expected);
            err_count++;
        end
        if (^bits[8:0] !== 1'b1 || bits[9] !== 1'b1) begin
            $display("error at %0t: host command %h has a bad parity or stop bit", $time,
                     bits[7:0]);
            err_count++;
        end
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_byte(input logic [7:0] value, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            data_oe <= ~frame[i];
            repeat (5) @(posedge CLK);
            clk_oe <= 1'b1;
            repeat (10) @(posedge CLK);
            clk_oe <= 1'b0;
            repeat (5) @(posedge CLK);
        end
        data_oe <= 1'b0;
        repeat (20) @(posedge CLK);
    endtask

    // Extremes and zero show up often
    task automatic pick_delta(output logic sign, output logic [7:0] value);
        case ($urandom_range(5))
            0: begin
                sign  = 1'b0;
                value = 8'h7F;
            end
            1: begin
                sign  = 1'b1;
                value = 8'h81;
            end
            2: begin
                sign  = 1'b0;
                value = 8'h00;
            end
            default: begin
                sign  = 1'($urandom_range(1));
                value = 8'($urandom);
            end
        endcase
    endtask

    initial begin
        logic [7:0] status;
        logic [7:0] dx;
        logic [7:0] dy;
        logic       xs;
        logic       ys;
        logic       bad;
        int         bad_idx;
        wait (RESETN === 1'b1);
        receive_cmd(CMD_RESET);
        send_byte(RSP_ACK, 1'b0);
        send_byte(RSP_SELFTEST, 1'b0);
        send_byte(RSP_ID, 1'b0);
        receive_cmd(CMD_ENABLE);
        send_byte(RSP_ACK, 1'b0);
        for (int n = 0; n < NUM_PACKETS; n++) begin
            pick_delta(xs, dx);
            pick_delta(ys, dy);
            status  = {($urandom_range(15) == 0), ($urandom_range(15) == 0),
                       ys, xs, 1'b1, 3'($urandom_range(7))};
            bad     = ($urandom_range(9) == 0);
            bad_idx = $urandom_range(2);
            // Host resyncs on bit 3, so keep it clear in the rest of a bad packet
            if (bad) begin
                dx[3] = 1'b0;
                dy[3] = 1'b0;
            end
            in_packet = 1'b1;
            send_byte(status, bad && bad_idx == 0);
            send_byte(dx, bad && bad_idx == 1);
            send_byte(dy, bad && bad_idx == 2);
            pkt_status = status;
            pkt_dx     = dx;
            pkt_dy     = dy;
            pkt_bad    = bad;
            in_packet  = 1'b0;
            -> pkt_sent;
            repeat (60) @(posedge CLK);
        end
        all_sent = 1'b1;
    end

endmodule

// File: dv/tb_mouse_top.sv
// PS/2 mouse subsystem testbench
`timescale 1ns/1ns

module tb_mouse_top;

    import mouse_pkg::*;

    localparam int NUM_PACKETS    = 200;
    localparam int MAX_X          = 159;
    localparam int MAX_Y          = 119;
    // Twice 33 bit times of 20 cycles per packet plus start-up margin
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 33 * 20 * 2 + 5000;

    logic       CLK = 1'b0;
    logic       RESETN = 1'b0;
    logic [7:0] BUS_ADDR = 8'h00;
    logic       BUS_WE = 1'b0;
    logic       INTERRUPT_ACK = 1'b0;
    logic [7:0] bus_drive = 8'h00;
    logic       bus_oe = 1'b0;
    wire  [7:0] BUS_DATA;
    tri1        CLK_MOUSE;
    tri1        DATA_MOUSE;
    wire        SEND_INTERRUPT;
    int         errors = 0;
    int         cycles = 0;
    int         ref_x = MAX_X / 2;
    int         ref_y = MAX_Y / 2;
    logic [7:0] ref_status = 8'h00;

    assign BUS_DATA = bus_oe ? bus_drive : 8'hzz;

    always #2 CLK = ~CLK;

    mouse_top #(.INHIBIT_CYCLES(40), .MAX_X(MAX_X), .MAX_Y(MAX_Y)) DUT (
        .CLK            (CLK),
        .RESETN         (RESETN),
        .CLK_MOUSE      (CLK_MOUSE),
        .DATA_MOUSE     (DATA_MOUSE),
        .BUS_DATA       (BUS_DATA),
        .BUS_ADDR       (BUS_ADDR),
        .BUS_WE         (BUS_WE),
        .SEND_INTERRUPT (SEND_INTERRUPT),
        .INTERRUPT_ACK  (INTERRUPT_ACK)
    );

    ps2_mouse_model #(.NUM_PACKETS(NUM_PACKETS)) u_mouse (
        .CLK        (CLK),
        .RESETN     (RESETN),
        .clk_mouse  (CLK_MOUSE),
        .data_mouse (DATA_MOUSE)
    );

    task automatic check_value(input logic [7:0] observed, input logic [7:0] expected,
                               input string what);
        if (observed !== expected) begin
            $display("mismatch at %0t: %s observed %h expected %h", $time, what, observed,
                     expected);
            errors++;
        end
    endtask

    // Apply one 9-bit delta and clamp the result to 0..max_pos
    function automatic int next_pos(input int pos, input logic [7:0] delta, input logic sign,
                                    input logic ovf, input int max_pos);
        int d;
        int sum;
        d   = ovf ? 0 : (sign ? int'(delta) - 256 : int'(delta));
        sum = pos + d;
        if (sum < 0) begin
            return 0;
        end
        return (sum > max_pos) ? max_pos : sum;
    endfunction

    task automatic bus_read(input logic [7:0] addr, output logic [7:0] value);
        @(posedge CLK);
        BUS_ADDR <= addr;
        BUS_WE   <= 1'b0;
        @(posedge CLK);
        BUS_ADDR <= 8'h00;
        @(negedge CLK);
        value = BUS_DATA;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge CLK);
        BUS_ADDR  <= addr;
        BUS_WE    <= 1'b1;
        bus_drive <= data;
        bus_oe    <= 1'b1;
        @(posedge CLK);
        BUS_ADDR <= 8'h00;
        BUS_WE   <= 1'b0;
        bus_oe   <= 1'b0;
    endtask

    task automatic check_registers(input string when);
        logic [7:0] value;
        bus_read(ADDR_STATUS, value);
        check_value(value, ref_status, {"status ", when});
        bus_read(ADDR_POS_X, value);
        check_value(value, 8'(ref_x), {"x position ", when});
        bus_read(ADDR_POS_Y, value);
        check_value(value, 8'(ref_y), {"y position ", when});
    endtask

    task automatic write_and_recheck;
        bus_write(ADDR_STATUS, 8'($urandom));
        bus_write(ADDR_POS_X, 8'($urandom));
        bus_write(ADDR_POS_Y, 8'($urandom));
        check_registers("after writes");
    endtask

    task automatic check_good_packet;
        int wait_cycles;
        wait_cycles = 0;
        while (SEND_INTERRUPT !== 1'b1 && wait_cycles < 50) begin
            @(negedge CLK);
            wait_cycles++;
        end
        check_value({7'd0, SEND_INTERRUPT}, 8'd1, "interrupt after packet");
        ref_status = u_mouse.pkt_status;
        ref_x = next_pos(ref_x, u_mouse.pkt_dx, ref_status[STAT_XS], ref_status[STAT_XO], MAX_X);
        ref_y = next_pos(ref_y, u_mouse.pkt_dy, ref_status[STAT_YS], ref_status[STAT_YO], MAX_Y);
        check_registers("after packet");
        // Interrupt is a level that waits for the ack
        check_value({7'd0, SEND_INTERRUPT}, 8'd1, "interrupt before ack");
        @(posedge CLK);
        INTERRUPT_ACK <= 1'b1;
        @(posedge CLK);
        INTERRUPT_ACK <= 1'b0;
        @(negedge CLK);
        check_value({7'd0, SEND_INTERRUPT}, 8'd0, "interrupt after ack");
    endtask

    // No interrupt and no register change until the next packet starts
    task automatic check_dropped_packet;
        logic seen_irq;
        seen_irq = SEND_INTERRUPT;
        check_registers("after corrupted packet");
        while (!u_mouse.in_packet && !u_mouse.all_sent) begin
            @(negedge CLK);
            seen_irq = seen_irq | SEND_INTERRUPT;
        end
        check_value({7'd0, seen_irq}, 8'd0, "interrupt after corrupted packet");
    endtask

    task automatic close_run;
        int total;
        total = errors + u_mouse.err_count;
        $display("run finished with %0d errors (%0d testbench, %0d mouse model)", total,
                 errors, u_mouse.err_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: packets not all received");
            errors++;
            close_run();
        end
    end

    initial begin
        void'($urandom(39149));
        repeat (16) @(posedge CLK);
        RESETN <= 1'b1;
        check_registers("after reset");
        write_and_recheck();
        for (int n = 0; n < NUM_PACKETS; n++) begin
            @(u_mouse.pkt_sent);
            if (u_mouse.pkt_bad) begin
                check_dropped_packet();
            end else begin
                check_good_packet();
            end
            if (n % 25 == 0) begin
                write_and_recheck();
            end
        end
        close_run();
    end

endmodule

// File: filelist.f
logic/mouse_pkg.sv
logic/ps2_receiver.sv
logic/ps2_transmitter.sv
logic/mouse_master.sv
logic/mouse_position.sv
logic/mouse_top.sv
dv/ps2_mouse_model.sv
dv/tb_mouse_top.sv

// File: Makefile
SOURCES = $(wildcard logic/*.sv dv/*.sv)

run: obj_dir/Vtb_mouse_top
	@out="$$(./obj_dir/Vtb_mouse_top)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

obj_dir/Vtb_mouse_top: filelist.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_mouse_top -f filelist.f

clean:
	rm -rf obj_dir

.PHONY: run clean
